//--- cpu_params.svh
`ifndef CPU_PARAMS_SVH
`define CPU_PARAMS_SVH

// Datapath and instruction word width
`define CPU_XLEN        16

// Memory depths in 16-bit words
`define CPU_IMEM_WORDS  256
`define CPU_DMEM_WORDS  256

// Opcode encodings in inst[15:12]
`define CPU_OP_ADD  4'd0
`define CPU_OP_SUB  4'd1
`define CPU_OP_XOR  4'd2
`define CPU_OP_SLL  4'd4
`define CPU_OP_SRA  4'd5
`define CPU_OP_ROR  4'd6
`define CPU_OP_LW   4'd8
`define CPU_OP_SW   4'd9
`define CPU_OP_LLB  4'd10
`define CPU_OP_LHB  4'd11
`define CPU_OP_B    4'd12
`define CPU_OP_PCS  4'd14
`define CPU_OP_HLT  4'd15

`endif

//--- cpuPkg.sv
`default_nettype none
`include "cpu_params.svh"

package cpuPkg;

  // Opcodes 3, 7 and 13 are unused and decode as no-ops
  typedef enum logic [3:0] {
    OP_ADD = `CPU_OP_ADD,
    OP_SUB = `CPU_OP_SUB,
    OP_XOR = `CPU_OP_XOR,
    OP_SLL = `CPU_OP_SLL,
    OP_SRA = `CPU_OP_SRA,
    OP_ROR = `CPU_OP_ROR,
    OP_LW  = `CPU_OP_LW,
    OP_SW  = `CPU_OP_SW,
    OP_LLB = `CPU_OP_LLB,
    OP_LHB = `CPU_OP_LHB,
    OP_B   = `CPU_OP_B,
    OP_PCS = `CPU_OP_PCS,
    OP_HLT = `CPU_OP_HLT
  } opcode_t;

  // Branch condition codes, inst[11:9]
  typedef enum logic [2:0] {
    CC_NEQ, CC_EQ, CC_GT, CC_LT, CC_GTE, CC_LTE, CC_OVFL, CC_UNCOND
  } cond_t;

  typedef struct packed {
    logic z;                          // Zero
    logic v;                          // Signed overflow
    logic n;                          // Negative
  } flags_t;

  typedef struct packed {
    logic                 valid;
    logic [`CPU_XLEN-1:0] inst;
    logic [`CPU_XLEN-1:0] pcNext;     // PC + 2 of this instruction
  } ifId_t;

  typedef struct packed {
    logic                 valid;
    opcode_t              opcode;
    logic [3:0]           rd;
    logic                 regWrite;
    logic                 memRead;
    logic                 memWrite;
    logic                 setZ;       // Updates Z flag
    logic                 setNV;      // Updates N and V flags
    logic                 halt;
    logic [`CPU_XLEN-1:0] opA;
    logic [`CPU_XLEN-1:0] opB;        // Store data for SW
    logic [`CPU_XLEN-1:0] imm;        // Already extended or shifted
    logic [`CPU_XLEN-1:0] pcNext;
  } idEx_t;

  typedef struct packed {
    logic                 valid;
    logic [3:0]           rd;
    logic                 regWrite;
    logic                 memRead;
    logic                 memWrite;
    logic                 halt;
    logic [`CPU_XLEN-1:0] result;     // ALU output or memory address
    logic [`CPU_XLEN-1:0] storeData;
  } exMw_t;

  typedef struct packed {
    logic                 valid;
    logic [3:0]           regAddr;    // Destination register number
    logic [`CPU_XLEN-1:0] data;
  } regWrite_t;

endpackage

`default_nettype wire

//--- pipeReg.sv
`timescale 1ns/1ps
`default_nettype none

module pipeReg import cpuPkg::*; #(
  parameter type payloadT = ifId_t      // Stage payload struct
) (
  input  wire     clk,
  input  wire     rstN,                 // Sync, active low
  input  wire     stall,                // Hold current payload
  input  wire     flush,                // Load a bubble
  input  payloadT d,
  output payloadT q
);

  always_ff @(posedge clk) begin
    if (!rstN || flush) begin
      q <= '0;                          // All-zero payload is a bubble
    end else if (!stall) begin
      q <= d;
    end
  end

  // The hazard unit must never ask for both at once on the same stage
  stallFlushExclusive: assert property (
    @(posedge clk) disable iff (!rstN) !(stall && flush)
  ) else $error("pipeReg: stall and flush high together");

endmodule

`default_nettype wire

//--- fetch.sv
`timescale 1ns/1ps
`default_nettype none
`include "cpu_params.svh"

module fetch import cpuPkg::*; (
  input  wire        clk,
  input  wire        rstN,
  input  wire        stall,             // From hazard unit
  input  wire        branchTaken,       // Resolved in ID
  input  wire [15:0] branchTarget,
  input  wire        haltSeen,          // HLT decoded, freeze fetch
  input  wire        progWe,            // Load port, only while in reset
  input  wire [7:0]  progAddr,          // Word address
  input  wire [15:0] progData,
  output logic [15:0] pc,
  output ifId_t      ifId
);

  logic [`CPU_XLEN-1:0] imem [`CPU_IMEM_WORDS];
  logic [15:0] pcPlus2;
  logic [15:0] nextPc;

  assign pcPlus2 = pc + 16'd2;

  always_comb begin
    if (stall || haltSeen) nextPc = pc;            // Freeze
    else if (branchTaken)  nextPc = branchTarget;  // Redirect from ID
    else                   nextPc = pcPlus2;
  end

  always_ff @(posedge clk) begin
    if (!rstN) pc <= '0;
    else       pc <= nextPc;
  end

  // Program load while the core is held in reset
  always_ff @(posedge clk) begin
    if (!rstN && progWe) imem[progAddr] <= progData;
  end

  assign ifId.valid  = !haltSeen;                  // Nothing past HLT enters ID
  assign ifId.inst   = imem[pc[$clog2(`CPU_IMEM_WORDS):1]];
  assign ifId.pcNext = pcPlus2;

  pcAligned: assert property (@(posedge clk) disable iff (!rstN) pc[0] == 1'b0)
    else $error("fetch: odd PC %h", pc);

endmodule

`default_nettype wire

//--- decode.sv
`timescale 1ns/1ps
`default_nettype none

module decode import cpuPkg::*; (
  input  wire        clk,
  input  wire        rstN,
  input  ifId_t      ifId,
  input  flags_t     flags,             // Flag register in EX
  input  regWrite_t  wbWrite,           // Write port from MW
  output idEx_t      idEx,
  output logic [3:0] srcA,
  output logic [3:0] srcB,
  output logic       useA,
  output logic       useB,
  output logic       isBranch,
  output logic       branchTaken,
  output logic [15:0] branchTarget,
  output logic       haltSeen
);

  logic [15:0] rf [16];                 // Register file, R0 never written
  opcode_t     op;
  logic        isArith, isShift, isLoad, isStore, isLoadByte, isPcs, isHlt;
  logic [15:0] dataA, dataB;
  logic [15:0] immVal;
  logic        condMet;
  logic        haltReg;

  ////////////////////////////////////////////////////////////////////////////
  // Field extraction
  ////////////////////////////////////////////////////////////////////////////
  assign op         = opcode_t'(ifId.inst[15:12]);
  assign isArith    = (op == OP_ADD) || (op == OP_SUB) || (op == OP_XOR);
  assign isShift    = (op == OP_SLL) || (op == OP_SRA) || (op == OP_ROR);
  assign isLoad     = (op == OP_LW);
  assign isStore    = (op == OP_SW);
  assign isLoadByte = (op == OP_LLB) || (op == OP_LHB);
  assign isPcs      = (op == OP_PCS);
  assign isHlt      = (op == OP_HLT);

  assign srcA = isLoadByte ? ifId.inst[11:8] : ifId.inst[7:4];  // LLB/LHB merge into rd
  assign srcB = isStore    ? ifId.inst[11:8] : ifId.inst[3:0];  // SW data reg
  assign useA = ifId.valid && (isArith || isShift || isLoad || isStore || isLoadByte);
  assign useB = ifId.valid && (isArith || isStore);

  always_comb begin
    case (op)
      OP_LW, OP_SW:   immVal = {{11{ifId.inst[3]}}, ifId.inst[3:0], 1'b0};  // Word offset
      OP_LLB, OP_LHB: immVal = {8'h00, ifId.inst[7:0]};
      default:        immVal = {12'h000, ifId.inst[3:0]};                   // Shift amount
    endcase
  end

  ////////////////////////////////////////////////////////////////////////////
  // Register file with write-through from MW
  ////////////////////////////////////////////////////////////////////////////
  always_ff @(posedge clk) begin
    if (wbWrite.valid) rf[wbWrite.regAddr] <= wbWrite.data;
  end

  assign dataA = (srcA == 4'd0) ? '0 :
                 (wbWrite.valid && wbWrite.regAddr == srcA) ? wbWrite.data : rf[srcA];
  assign dataB = (srcB == 4'd0) ? '0 :
                 (wbWrite.valid && wbWrite.regAddr == srcB) ? wbWrite.data : rf[srcB];

  ////////////////////////////////////////////////////////////////////////////
  // Branch resolution
  ////////////////////////////////////////////////////////////////////////////
  always_comb begin
    case (cond_t'(ifId.inst[11:9]))
      CC_NEQ:  condMet = !flags.z;
      CC_EQ:   condMet = flags.z;
      CC_GT:   condMet = !flags.z && !flags.n;
      CC_LT:   condMet = flags.n;
      CC_GTE:  condMet = flags.z || !flags.n;
      CC_LTE:  condMet = flags.n || flags.z;
      CC_OVFL: condMet = flags.v;
      default: condMet = 1'b1;                    // Unconditional
    endcase
  end

  assign isBranch     = ifId.valid && (op == OP_B);
  assign branchTaken  = isBranch && condMet;
  assign branchTarget = ifId.pcNext + {{6{ifId.inst[8]}}, ifId.inst[8:0], 1'b0};

  // Sticky once HLT has passed through ID
  always_ff @(posedge clk) begin
    if (!rstN)                    haltReg <= 1'b0;
    else if (ifId.valid && isHlt) haltReg <= 1'b1;
  end
  assign haltSeen = haltReg || (ifId.valid && isHlt);

  always_comb begin
    idEx.valid    = ifId.valid;
    idEx.opcode   = op;
    idEx.rd       = ifId.inst[11:8];
    idEx.regWrite = ifId.valid && (isArith || isShift || isLoad || isLoadByte || isPcs);
    idEx.memRead  = ifId.valid && isLoad;
    idEx.memWrite = ifId.valid && isStore;
    idEx.setZ     = ifId.valid && (isArith || isShift);
    idEx.setNV    = ifId.valid && ((op == OP_ADD) || (op == OP_SUB));
    idEx.halt     = ifId.valid && isHlt;
    idEx.opA      = dataA;
    idEx.opB      = dataB;
    idEx.imm      = immVal;
    idEx.pcNext   = ifId.pcNext;
  end

  // MW must filter R0 writes before they reach the register file
  noR0Write: assert property (
    @(posedge clk) disable iff (!rstN) wbWrite.valid |-> (wbWrite.regAddr != 4'd0)
  ) else $error("decode: register file write to R0");

endmodule

`default_nettype wire

//--- execute.sv
`timescale 1ns/1ps
`default_nettype none

module execute import cpuPkg::*; (
  input  wire    clk,
  input  wire    rstN,
  input  idEx_t  idEx,
  output exMw_t  exMw,
  output flags_t flags                  // Flag register, read by branch in ID
);

  logic [15:0] sum, diff, satSum, satDiff;
  logic        sumOvf, diffOvf;
  logic [31:0] rotWide;
  logic [15:0] aluOut;
  logic        ovf;

  assign sum     = idEx.opA + idEx.opB;
  assign diff    = idEx.opA - idEx.opB;
  assign sumOvf  = (idEx.opA[15] == idEx.opB[15]) && (sum[15] != idEx.opA[15]);
  assign diffOvf = (idEx.opA[15] != idEx.opB[15]) && (diff[15] != idEx.opA[15]);
  assign satSum  = sumOvf  ? (idEx.opA[15] ? 16'h8000 : 16'h7FFF) : sum;   // Clamp
  assign satDiff = diffOvf ? (idEx.opA[15] ? 16'h8000 : 16'h7FFF) : diff;
  assign rotWide = {idEx.opA, idEx.opA} >> idEx.imm[3:0];                   // Rotate right

  always_comb begin
    ovf = 1'b0;
    case (idEx.opcode)
      OP_ADD: begin
        aluOut = satSum;
        ovf    = sumOvf;
      end
      OP_SUB: begin
        aluOut = satDiff;
        ovf    = diffOvf;
      end
      OP_XOR:        aluOut = idEx.opA ^ idEx.opB;
      OP_SLL:        aluOut = idEx.opA << idEx.imm[3:0];
      OP_SRA:        aluOut = $signed(idEx.opA) >>> idEx.imm[3:0];
      OP_ROR:        aluOut = rotWide[15:0];
      OP_LW, OP_SW:  aluOut = idEx.opA + idEx.imm;                 // Base plus byte offset
      OP_LLB:        aluOut = (idEx.opA & 16'hFF00) | idEx.imm;
      OP_LHB:        aluOut = (idEx.opA & 16'h00FF) | (idEx.imm << 8);
      OP_PCS:        aluOut = idEx.pcNext;
      default:       aluOut = '0;                                  // HLT and no-ops
    endcase
  end

  // Flags only move for real instructions, never for bubbles
  always_ff @(posedge clk) begin
    if (!rstN) begin
      flags <= '0;
    end else if (idEx.valid) begin
      if (idEx.setZ) flags.z <= (aluOut == 16'h0000);
      if (idEx.setNV) begin
        flags.n <= aluOut[15];
        flags.v <= ovf;
      end
    end
  end

  always_comb begin
    exMw.valid     = idEx.valid;
    exMw.rd        = idEx.rd;
    exMw.regWrite  = idEx.regWrite;
    exMw.memRead   = idEx.memRead;
    exMw.memWrite  = idEx.memWrite;
    exMw.halt      = idEx.halt;
    exMw.result    = aluOut;
    exMw.storeData = idEx.opB;        // SW data register
  end

endmodule

`default_nettype wire

//--- dataMemory.sv
`timescale 1ns/1ps
`default_nettype none
`include "cpu_params.svh"

module dataMemory import cpuPkg::*; (
  input  wire                  clk,
  input  wire  [15:0]          addr,       // Byte address
  input  wire  [`CPU_XLEN-1:0] writeData,
  input  wire                  writeEn,
  output logic [`CPU_XLEN-1:0] readData
);

  logic [`CPU_XLEN-1:0] mem [`CPU_DMEM_WORDS];
  logic [$clog2(`CPU_DMEM_WORDS)-1:0] wordIdx;

  assign wordIdx  = addr[$clog2(`CPU_DMEM_WORDS):1];
  assign readData = mem[wordIdx];          // Async read, LW data lands in MW

  always_ff @(posedge clk) begin
    if (writeEn) mem[wordIdx] <= writeData;
  end

  // Stores must be word aligned
  storeAligned: assert property (@(posedge clk) writeEn |-> (addr[0] == 1'b0))
    else $error("dataMemory: odd store address %h", addr);

endmodule

`default_nettype wire

//--- hazardUnit.sv
`timescale 1ns/1ps
`default_nettype none

module hazardUnit import cpuPkg::*; (
  input  wire [3:0] srcA,
  input  wire [3:0] srcB,
  input  wire       useA,
  input  wire       useB,
  input  wire       isBranch,
  input  idEx_t     idEx,               // Instruction now in EX
  input  wire       branchTaken,
  output logic      stallFront,         // Hold PC and IF/ID, bubble into ID/EX
  output logic      flushIfId           // Drop wrong-path fetch
);

  logic exWrites;                       // EX will write a real register
  logic rawHazard;
  logic flagHazard;

  assign exWrites   = idEx.valid && idEx.regWrite && (idEx.rd != 4'd0);  // R0 exempt
  assign rawHazard  = exWrites && ((useA && (srcA == idEx.rd)) ||
                                   (useB && (srcB == idEx.rd)));
  // Branch must see flags from the instruction ahead of it
  assign flagHazard = isBranch && idEx.valid && (idEx.setZ || idEx.setNV);

  // MW results come through the register file, so only EX matters
  assign stallFront = rawHazard || flagHazard;
  assign flushIfId  = branchTaken && !stallFront;

endmodule

`default_nettype wire

//--- cpu.sv
`timescale 1ns/1ps
`default_nettype none

module cpu import cpuPkg::*; (
  input  wire         clk,
  input  wire         rstN,             // Sync, active low
  input  wire         progWe,           // Instruction load port
  input  wire  [7:0]  progAddr,
  input  wire  [15:0] progData,
  output logic [15:0] pc,
  output logic        hlt,
  output regWrite_t   wb                // Retirement port, also regfile write
);

  ifId_t  ifIdD, ifIdQ;
  idEx_t  idExD, idExQ;
  exMw_t  exMwD, exMwQ;
  flags_t flags;
  logic [3:0]  srcA, srcB;
  logic        useA, useB, isBranch;
  logic        branchTaken, haltSeen;
  logic [15:0] branchTarget;
  logic        stallFront, flushIfId;
  logic [15:0] memReadData;
  logic        hltReg;

  ////////////////////////////////////////////////////////////////////////////
  // IF, ID, EX
  ////////////////////////////////////////////////////////////////////////////
  fetch uFetch (
    .clk, .rstN, .stall(stallFront), .branchTaken, .branchTarget, .haltSeen,
    .progWe, .progAddr, .progData, .pc, .ifId(ifIdD)
  );

  pipeReg #(.payloadT(ifId_t)) ifIdReg (
    .clk, .rstN, .stall(stallFront), .flush(flushIfId), .d(ifIdD), .q(ifIdQ)
  );

  decode uDecode (
    .clk, .rstN, .ifId(ifIdQ), .flags, .wbWrite(wb), .idEx(idExD),
    .srcA, .srcB, .useA, .useB, .isBranch, .branchTaken, .branchTarget, .haltSeen
  );

  pipeReg #(.payloadT(idEx_t)) idExReg (
    .clk, .rstN, .stall(1'b0), .flush(stallFront), .d(idExD), .q(idExQ)  // Bubble on stall
  );

  execute uExecute (.clk, .rstN, .idEx(idExQ), .exMw(exMwD), .flags);

  pipeReg #(.payloadT(exMw_t)) exMwReg (
    .clk, .rstN, .stall(1'b0), .flush(1'b0), .d(exMwD), .q(exMwQ)
  );

  hazardUnit uHazard (
    .srcA, .srcB, .useA, .useB, .isBranch, .idEx(idExQ), .branchTaken,
    .stallFront, .flushIfId
  );

  ////////////////////////////////////////////////////////////////////////////
  // MW
  ////////////////////////////////////////////////////////////////////////////
  dataMemory uDataMem (
    .clk, .addr(exMwQ.result), .writeData(exMwQ.storeData),
    .writeEn(exMwQ.valid && exMwQ.memWrite), .readData(memReadData)
  );

  always_comb begin
    wb.valid   = exMwQ.valid && exMwQ.regWrite && (exMwQ.rd != 4'd0);  // No R0, no bubbles
    wb.regAddr = exMwQ.rd;
    wb.data    = exMwQ.memRead ? memReadData : exMwQ.result;
  end

  // HLT reaching MW, held until reset
  always_ff @(posedge clk) begin
    if (!rstN)                         hltReg <= 1'b0;
    else if (exMwQ.valid && exMwQ.halt) hltReg <= 1'b1;
  end
  assign hlt = hltReg || (exMwQ.valid && exMwQ.halt);

  // Fetch freeze in IF must keep the pipe empty behind HLT
  quietAfterHalt: assert property (@(posedge clk) disable iff (!rstN) hltReg |-> !wb.valid)
    else $error("cpu: retirement after halt");

endmodule

`default_nettype wire

//--- tbCpu.sv
`timescale 1ns/1ps
`default_nettype none
`include "cpu_params.svh"

module tbCpu import cpuPkg::*; ();

  localparam int numPrograms = 8;
  localparam int prologueLen = 18;        // 7 clears, 7 byte loads, 4 stores
  localparam int bodyLen     = 22;        // Random part, HLT follows
  localparam int watchdogNs  = numPrograms * 200 * 20;

  logic        clk;
  logic        rstN;
  logic        progWe;
  logic [7:0]  progAddr;
  logic [15:0] progData;
  logic [15:0] pc;
  logic        hlt;
  regWrite_t   wb;

  logic [31:0] lfsrState;
  logic [15:0] prog [64];
  int          progLen;
  logic [19:0] expQ [$];                  // Expected {reg, data} in retirement order
  logic [15:0] expFinalPc;
  logic        checking;
  logic        rstLowAtEdge = 1'b0;       // Reset was low at the last rising edge

  cpu cpu_i (.clk, .rstN, .progWe, .progAddr, .progData, .pc, .hlt, .wb);

  always #10 clk = ~clk;

  ////////////////////////////////////////////////////////////////////////////
  // Random source and program generator
  ////////////////////////////////////////////////////////////////////////////
  function automatic logic [31:0] lfsrNext(input logic [31:0] s);
    return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};   // x^32 + x^22 + x^2 + x + 1
  endfunction

  function automatic logic [15:0] randBits(input int n);
    logic [15:0] val;
    int          i;
    val = '0;
    for (i = 0; i < n; i++) begin
      lfsrState = lfsrNext(lfsrState);
      val = {val[14:0], lfsrState[0]};
    end
    return val;
  endfunction

  function automatic logic [3:0] pickSrc();
    return 4'(randBits(3));               // R0..R7
  endfunction

  function automatic logic [3:0] pickDest();
    logic [3:0] r;
    r = 4'(randBits(3));
    return (r == 4'd1) ? 4'd0 : r;        // R1 stays the memory base
  endfunction

  task automatic genProgram();
    int         r;
    int         a;
    int         kind;
    int         maxOff;
    logic [3:0] opc, dst, s1, s2;
    logic [7:0] byteVal;
    a = 0;
    for (r = 1; r < 8; r++) begin
      prog[a] = {`CPU_OP_XOR, 4'(r), 8'h00};         // Known zero first
      a++;
    end
    for (r = 1; r < 8; r++) begin
      opc     = (randBits(1) == 16'd1) ? `CPU_OP_LHB : `CPU_OP_LLB;
      byteVal = 8'(randBits(8));
      if (r == 1) byteVal[0] = 1'b0;                  // Memory base stays word aligned
      prog[a] = {opc, 4'(r), byteVal};
      a++;
    end
    for (r = 0; r < 4; r++) begin
      prog[a] = {`CPU_OP_SW, 4'(r + 2), 4'd1, 4'(r)}; // Fill every LW slot
      a++;
    end
    for (r = 0; r < bodyLen; r++) begin
      kind = int'(randBits(4));
      dst  = pickDest();
      s1   = pickSrc();
      s2   = pickSrc();
      case (kind)
        0, 15:  prog[a] = {`CPU_OP_ADD, dst, s1, s2};
        1, 14:  prog[a] = {`CPU_OP_SUB, dst, s1, s2};
        2:      prog[a] = {`CPU_OP_XOR, dst, s1, s2};
        3:      prog[a] = {`CPU_OP_SLL, dst, s1, 4'(randBits(4))};
        4:      prog[a] = {`CPU_OP_SRA, dst, s1, 4'(randBits(4))};
        5:      prog[a] = {`CPU_OP_ROR, dst, s1, 4'(randBits(4))};
        6:      prog[a] = {`CPU_OP_LW, dst, 4'd1, 4'(randBits(2))};
        7:      prog[a] = {`CPU_OP_SW, s1, 4'd1, 4'(randBits(2))};
        8:      prog[a] = {`CPU_OP_LLB, dst, 8'(randBits(8))};
        9:      prog[a] = {`CPU_OP_LHB, dst, 8'(randBits(8))};
        11:     prog[a] = {`CPU_OP_PCS, dst, 8'h00};
        default: begin
          maxOff = prologueLen + bodyLen - a - 1;     // Forward, at most onto HLT
          if (maxOff > 7) maxOff = 7;
          prog[a] = {`CPU_OP_B, 3'(randBits(3)), 9'(int'(randBits(3)) % (maxOff + 1))};
        end
      endcase
      a++;
    end
    prog[a] = {`CPU_OP_HLT, 12'h000};
    progLen = a + 1;
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // In-order ISA model
  ////////////////////////////////////////////////////////////////////////////
  function automatic void runModel();
    logic [15:0] regs [16];
    logic [15:0] dmem [256];
    logic [15:0] pcM, pcNext, inst, opA, opB, res, addr;
    logic [3:0]  rd;
    logic        z, v, n, wr, taken;
    int          sum;
    int          k;
    int          steps;
    expQ.delete();
    regs[0] = '0;
    z = 1'b0;
    v = 1'b0;
    n = 1'b0;
    pcM = '0;
    for (steps = 0; steps < 64; steps++) begin
      inst   = prog[pcM[6:1]];
      pcNext = pcM + 16'd2;
      rd     = inst[11:8];
      opA    = regs[inst[7:4]];
      opB    = regs[inst[3:0]];
      addr   = opA + {{11{inst[3]}}, inst[3:0], 1'b0};  // Word offset in bytes
      wr     = 1'b1;
      res    = '0;
      case (inst[15:12])
        `CPU_OP_ADD, `CPU_OP_SUB: begin
          if (inst[15:12] == `CPU_OP_ADD) sum = int'($signed(opA)) + int'($signed(opB));
          else                            sum = int'($signed(opA)) - int'($signed(opB));
          v   = (sum > 32767) || (sum < -32768);
          res = v ? ((sum > 0) ? 16'h7FFF : 16'h8000) : 16'(sum);  // Saturate
          n   = res[15];
          z   = (res == 16'h0000);
        end
        `CPU_OP_XOR: begin
          res = opA ^ opB;
          z   = (res == 16'h0000);
        end
        `CPU_OP_SLL, `CPU_OP_SRA, `CPU_OP_ROR: begin
          if (inst[15:12] == `CPU_OP_SLL)      res = opA << inst[3:0];
          else if (inst[15:12] == `CPU_OP_SRA) res = $signed(opA) >>> inst[3:0];
          else begin
            res = opA;
            for (k = 0; k < int'(inst[3:0]); k++) res = {res[0], res[15:1]};
          end
          z = (res == 16'h0000);
        end
        `CPU_OP_LW:  res = dmem[addr[8:1]];
        `CPU_OP_SW: begin
          dmem[addr[8:1]] = regs[rd];
          wr = 1'b0;
        end
        `CPU_OP_LLB: res = (regs[rd] & 16'hFF00) | {8'h00, inst[7:0]};
        `CPU_OP_LHB: res = (regs[rd] & 16'h00FF) | {inst[7:0], 8'h00};
        `CPU_OP_PCS: res = pcNext;
        `CPU_OP_B: begin
          wr = 1'b0;
          case (cond_t'(inst[11:9]))
            CC_NEQ:  taken = !z;
            CC_EQ:   taken = z;
            CC_GT:   taken = !z && !n;
            CC_LT:   taken = n;
            CC_GTE:  taken = z || !n;
            CC_LTE:  taken = n || z;
            CC_OVFL: taken = v;
            default: taken = 1'b1;
          endcase
          if (taken) pcNext = pcNext + {{6{inst[8]}}, inst[8:0], 1'b0};
        end
        `CPU_OP_HLT: begin
          expFinalPc = pcNext;              // Fetch stops one word past HLT
          return;
        end
        default: wr = 1'b0;
      endcase
      if (wr && rd != 4'd0) begin
        regs[rd] = res;
        expQ.push_back({rd, res});
      end
      pcM = pcNext;
    end
  endfunction

  ////////////////////////////////////////////////////////////////////////////
  // Checking
  ////////////////////////////////////////////////////////////////////////////
  task automatic failRun(input string msg);
    $display("%s", msg);
    $display("*** FAILED ***");
    $fatal(1, "Stopping at first error");
  endtask

  always @(posedge clk) rstLowAtEdge <= !rstN;

  // Outputs settle after the rising edge, so look at them on the falling one
  always @(negedge clk) begin : compare
    logic [19:0] expEntry;
    if (rstLowAtEdge) begin
      assert (pc == 16'h0000)
        else failRun($sformatf("Mismatch pc in reset: got %h expected %h", pc, 16'h0000));
      assert (!hlt) else failRun("hlt was high while reset was held");
      assert (!wb.valid) else failRun("wb.valid was high while reset was held");
    end else if (checking) begin
      if (wb.valid) begin
        assert (expQ.size() > 0) else failRun("A register write retired that the model never made");
        expEntry = expQ.pop_front();
        assert (wb.regAddr == expEntry[19:16])
          else failRun($sformatf("Mismatch wb.regAddr: got %h expected %h",
                                 wb.regAddr, expEntry[19:16]));
        assert (wb.data == expEntry[15:0])
          else failRun($sformatf("Mismatch wb.data (R%0d): got %h expected %h",
                                 wb.regAddr, wb.data, expEntry[15:0]));
      end
      if (hlt) begin
        assert (expQ.size() == 0)
          else failRun($sformatf("hlt rose with %0d writes still missing", expQ.size()));
        assert (pc == expFinalPc)
          else failRun($sformatf("Mismatch pc after halt: got %h expected %h", pc, expFinalPc));
      end
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // Main sequence and watchdog
  ////////////////////////////////////////////////////////////////////////////
  initial begin
    int p;
    int i;
    clk       = 1'b0;
    rstN      = 1'b0;
    progWe    = 1'b0;
    progAddr  = '0;
    progData  = '0;
    checking  = 1'b0;
    lfsrState = 32'h2776_f75e;
    for (p = 0; p < numPrograms; p++) begin
      checking = 1'b0;                      // Before the queue is rebuilt
      genProgram();
      runModel();
      rstN = 1'b0;
      for (i = 0; i < progLen; i++) begin
        progWe   = 1'b1;
        progAddr = 8'(i);
        progData = prog[i];
        @(negedge clk);
      end
      progWe = 1'b0;
      repeat (3) @(negedge clk);
      rstN     = 1'b1;
      checking = 1'b1;
      while (!hlt) @(negedge clk);
      repeat (6) @(negedge clk);            // Stray writes or PC drift show up here
    end
    $display("*** PASSED ***");
    $finish;
  end

  initial begin
    #(watchdogNs);
    failRun("Timeout, the programs did not all reach HLT in time");
  end

endmodule

`default_nettype wire

//--- filelist.f
+incdir+.
cpuPkg.sv
pipeReg.sv
fetch.sv
decode.sv
execute.sv
dataMemory.sv
hazardUnit.sv
cpu.sv
tbCpu.sv

//--- Makefile
.PHONY: sim clean

sim:
	verilator --binary --timing --assert --top-module tbCpu -f filelist.f -o simCpu
	out=$$(./obj_dir/simCpu); \
	echo "$$out"; \
	echo "$$out" | grep -qF '*** PASSED ***'

clean:
	rm -rf obj_dir
